// ==== vlog.f ====
rtl/mem_pkg.sv
rtl/mem_bus_if.sv
rtl/mem_ctrl.sv
rtl/mem_lsu_align.sv
rtl/mem_dstb.sv
rtl/mem_clint.sv
rtl/mem_csr.sv
rtl/mem_top.sv
testbench/tb_wb_mem.sv
testbench/tb_mem_top.sv

// ==== testbench/tb_mem_top.sv ====
module tb_mem_top;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    localparam int              CLK_PERIOD   = 10;
    localparam int              RESET_CYCLES = 4;
    localparam int              ROW_CYCLES   = 20;
    localparam logic [XLEN-1:0] CLINT_BASE   = 64'h0200_0000;
    localparam logic [XLEN-1:0] MTVEC_RESET  = 64'h8000_0100;
    localparam logic [XLEN-1:0] EXT          = 64'h8000_1000;
    localparam logic [XLEN-1:0] MTIMECMP     = CLINT_BASE + CLINT_MTIMECMP_OFS;

    typedef struct {
        string           name;
        logic            rd;
        logic            wr;
        ls_size_e        size;
        logic            uns;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;    // Store data and CSR write data.
        logic [XLEN-1:0] alu;
        csr_op_e         op;
        logic [11:0]     csr;
        logic            ecall;
        logic            mret;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] exp_data;
        logic            exp_redir;
        logic [XLEN-1:0] exp_pc;
    } row_t;

    logic            clk;
    logic            reset_i;
    logic            inst_valid_i;
    logic            mem_read_i;
    logic            mem_write_i;
    ls_size_e        ls_size_i;
    logic            load_unsigned_i;
    logic [XLEN-1:0] addr_i;
    logic [XLEN-1:0] store_data_i;
    logic [XLEN-1:0] alu_result_i;
    csr_op_e         csr_op_i;
    logic [11:0]     csr_index_i;
    logic [XLEN-1:0] csr_wdata_i;
    logic            inst_ecall_i;
    logic            inst_mret_i;
    logic [XLEN-1:0] inst_pc_i;
    logic            access_ok_o;
    logic [XLEN-1:0] rd_data_o;
    logic            redirect_o;
    logic [XLEN-1:0] nxt_pc_o;
    logic            wb_cyc_o;
    logic            wb_stb_o;
    logic            wb_we_o;
    logic [XLEN-1:0] wb_adr_o;
    logic [XLEN-1:0] wb_dat_o;
    logic [7:0]      wb_sel_o;
    logic [XLEN-1:0] wb_dat_i;
    logic            wb_ack_i;

    row_t        rows[$];
    logic        table_ready = 1'b0;
    int unsigned errors = 0;

    mem_top #(
        .CLINT_BASE  (CLINT_BASE),
        .MTVEC_RESET (MTVEC_RESET)
    ) uut (
        .clk (clk), .reset_i (reset_i), .inst_valid_i (inst_valid_i),
        .mem_read_i (mem_read_i), .mem_write_i (mem_write_i), .ls_size_i (ls_size_i),
        .load_unsigned_i (load_unsigned_i), .addr_i (addr_i), .store_data_i (store_data_i),
        .alu_result_i (alu_result_i), .csr_op_i (csr_op_i), .csr_index_i (csr_index_i),
        .csr_wdata_i (csr_wdata_i), .inst_ecall_i (inst_ecall_i), .inst_mret_i (inst_mret_i),
        .inst_pc_i (inst_pc_i), .access_ok_o (access_ok_o), .rd_data_o (rd_data_o),
        .redirect_o (redirect_o), .nxt_pc_o (nxt_pc_o), .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o), .wb_we_o (wb_we_o), .wb_adr_o (wb_adr_o), .wb_dat_o (wb_dat_o),
        .wb_sel_o (wb_sel_o), .wb_dat_i (wb_dat_i), .wb_ack_i (wb_ack_i)
    );

    tb_wb_mem #(
        .SEED (32'heaa0_6611)
    ) ext_mem (
        .clk_i (clk), .cyc_i (wb_cyc_o), .stb_i (wb_stb_o), .we_i (wb_we_o),
        .adr_i (wb_adr_o), .dat_i (wb_dat_o), .sel_i (wb_sel_o),
        .dat_o (wb_dat_i), .ack_o (wb_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic row_t blank_row(string name);
        row_t r;
        r.name = name;
        r.rd = 1'b0;
        r.wr = 1'b0;
        r.size = LS_DOUBLE;
        r.uns = 1'b0;
        r.addr = '0;
        r.wdata = '0;
        r.alu = '0;
        r.op = CSR_NONE;
        r.csr = 12'h000;
        r.ecall = 1'b0;
        r.mret = 1'b0;
        r.pc = 64'h8000_0000;
        r.exp_data = '0;    // Stores return the ALU result, zero here.
        r.exp_redir = 1'b0;
        r.exp_pc = '0;
        return r;
    endfunction

    task automatic add_store(string name, ls_size_e size, logic [XLEN-1:0] addr,
                             logic [XLEN-1:0] data);
        row_t r;
        r = blank_row(name);
        r.wr = 1'b1;
        r.size = size;
        r.addr = addr;
        r.wdata = data;
        rows.push_back(r);
    endtask

    task automatic add_load(string name, ls_size_e size, logic uns, logic [XLEN-1:0] addr,
                            logic [XLEN-1:0] exp);
        row_t r;
        r = blank_row(name);
        r.rd = 1'b1;
        r.size = size;
        r.uns = uns;
        r.addr = addr;
        r.exp_data = exp;
        rows.push_back(r);
    endtask

    task automatic add_csr(string name, csr_op_e op, logic [11:0] idx, logic [XLEN-1:0] wdata,
                           logic [XLEN-1:0] exp_old);
        row_t r;
        r = blank_row(name);
        r.op = op;
        r.csr = idx;
        r.wdata = wdata;
        r.exp_data = exp_old;
        rows.push_back(r);
    endtask

    task automatic add_ctrl(string name, logic ecall, logic mret, logic [XLEN-1:0] alu,
                            logic [XLEN-1:0] pc, logic exp_redir, logic [XLEN-1:0] exp_pc);
        row_t r;
        r = blank_row(name);
        r.ecall = ecall;
        r.mret = mret;
        r.alu = alu;
        r.pc = pc;
        r.exp_data = alu;
        r.exp_redir = exp_redir;
        r.exp_pc = exp_pc;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // External memory, each size, then sign and zero extension.
        add_store("sd", LS_DOUBLE, EXT, 64'h8877_6655_4433_2211);
        add_store("sb", LS_BYTE, EXT + 64'hb, 64'h1234_56f0);
        add_store("sh", LS_HALF, EXT + 64'hc, 64'habcd_8001);
        add_store("sw", LS_WORD, EXT + 64'h10, 64'h1111_2222_8765_4321);
        add_load("ld", LS_DOUBLE, 1'b0, EXT, 64'h8877_6655_4433_2211);
        add_load("lb", LS_BYTE, 1'b0, EXT + 64'hb, 64'hffff_ffff_ffff_fff0);
        add_load("lbu", LS_BYTE, 1'b1, EXT + 64'hb, 64'h0000_0000_0000_00f0);
        add_load("lb_lane7", LS_BYTE, 1'b0, EXT + 64'h7, 64'hffff_ffff_ffff_ff88);
        add_load("lh", LS_HALF, 1'b0, EXT + 64'hc, 64'hffff_ffff_ffff_8001);
        add_load("lhu", LS_HALF, 1'b1, EXT + 64'hc, 64'h0000_0000_0000_8001);
        add_load("lh_positive", LS_HALF, 1'b0, EXT + 64'h2, 64'h0000_0000_0000_4433);
        add_load("lw", LS_WORD, 1'b0, EXT + 64'h10, 64'hffff_ffff_8765_4321);
        add_load("lwu", LS_WORD, 1'b1, EXT + 64'h10, 64'h0000_0000_8765_4321);
        add_load("lw_upper", LS_WORD, 1'b0, EXT + 64'h4, 64'hffff_ffff_8877_6655);
        // CLINT, compare value far beyond mtime.
        add_store("clint_sd_mtimecmp", LS_DOUBLE, MTIMECMP, 64'h0000_0100_0000_0000);
        add_load("clint_ld_mtimecmp", LS_DOUBLE, 1'b0, MTIMECMP, 64'h0000_0100_0000_0000);
        add_csr("csrw_mscratch", CSR_WRITE, CSR_MSCRATCH, 64'hdead_beef_0000_00f0, '0);
        add_csr("csrs_mscratch", CSR_SET, CSR_MSCRATCH, 64'h0f, 64'hdead_beef_0000_00f0);
        add_csr("csrc_mscratch", CSR_CLEAR, CSR_MSCRATCH, 64'hf0, 64'hdead_beef_0000_00ff);
        add_csr("read_mscratch", CSR_SET, CSR_MSCRATCH, '0, 64'hdead_beef_0000_000f);
        add_csr("csrw_mtvec", CSR_WRITE, CSR_MTVEC, 64'h8000_0200, MTVEC_RESET);
        add_csr("csrs_mtvec", CSR_SET, CSR_MTVEC, 64'h4000_0000, 64'h8000_0200);
        add_csr("csrc_mtvec", CSR_CLEAR, CSR_MTVEC, 64'h4000_0000, 64'hc000_0200);
        add_csr("read_mtvec", CSR_SET, CSR_MTVEC, '0, 64'h8000_0200);
        add_ctrl("alu_only", 1'b0, 1'b0, 64'h0123_4567_89ab_cdef, 64'h8000_0010, 1'b0, '0);
        add_ctrl("ecall", 1'b1, 1'b0, '0, 64'h8000_0040, 1'b1, 64'h8000_0200);
        add_csr("read_mepc", CSR_SET, CSR_MEPC, '0, 64'h8000_0040);
        add_csr("read_mcause", CSR_SET, CSR_MCAUSE, '0, 64'd11);
        add_ctrl("mret", 1'b0, 1'b1, '0, 64'h8000_0300, 1'b1, 64'h8000_0040);
        // Timer interrupt, global enable last so that it hits the next ALU op.
        add_csr("csrs_mie_mtie", CSR_SET, CSR_MIE, 64'h80, '0);
        add_store("clint_mtimecmp_zero", LS_DOUBLE, MTIMECMP, '0);
        add_csr("read_mip", CSR_SET, CSR_MIP, '0, 64'h80);
        add_csr("csrs_mstatus_mie", CSR_SET, CSR_MSTATUS, 64'h08, 64'h80);
        add_ctrl("timer_irq", 1'b0, 1'b0, 64'h55, 64'h8000_0400, 1'b1, 64'h8000_0200);
        add_csr("read_mcause_irq", CSR_SET, CSR_MCAUSE, '0, CAUSE_TIMER_INT);
        add_csr("read_mstatus_irq", CSR_SET, CSR_MSTATUS, '0, 64'h80);
        add_csr("read_mepc_irq", CSR_SET, CSR_MEPC, '0, 64'h8000_0400);
    endtask

    task automatic check_data(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s rd_data expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_redirect(string name, logic exp_r, logic [XLEN-1:0] exp_pc,
                                  logic act_r, logic [XLEN-1:0] act_pc);
        if (act_r !== exp_r) begin
            $display("MISMATCH %s redirect expected %b actual %b", name, exp_r, act_r);
            errors++;
        end else if (exp_r && act_pc !== exp_pc) begin
            $display("MISMATCH %s nxt_pc expected %h actual %h", name, exp_pc, act_pc);
            errors++;
        end
    endtask

    task automatic run_row(row_t r);
        @(negedge clk);
        inst_valid_i = 1'b1;
        mem_read_i = r.rd;
        mem_write_i = r.wr;
        ls_size_i = r.size;
        load_unsigned_i = r.uns;
        addr_i = r.addr;
        store_data_i = r.wdata;
        alu_result_i = r.alu;
        csr_op_i = r.op;
        csr_index_i = r.csr;
        csr_wdata_i = r.wdata;
        inst_ecall_i = r.ecall;
        inst_mret_i = r.mret;
        inst_pc_i = r.pc;
        @(negedge clk);
        while (!access_ok_o) begin
            @(negedge clk);
        end
        check_data(r.name, r.exp_data, rd_data_o);
        check_redirect(r.name, r.exp_redir, r.exp_pc, redirect_o, nxt_pc_o);
    endtask

    // The CLINT window must stay off the external port.
    always @(posedge clk) begin
        if (!reset_i && wb_cyc_o && wb_adr_o[XLEN-1:16] == CLINT_BASE[XLEN-1:16]) begin
            $display("CLINT address %h reached the external Wishbone port", wb_adr_o);
            errors++;
        end
    end

    initial begin
        wait (table_ready);
        #(CLK_PERIOD * (rows.size() * ROW_CYCLES + RESET_CYCLES));
        $display("Timeout: the DUT did not finish the tests in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int unsigned errors_before;
        int unsigned passed;
        reset_i = 1'b1;
        inst_valid_i = 1'b0;
        mem_read_i = 1'b0;
        mem_write_i = 1'b0;
        ls_size_i = LS_DOUBLE;
        load_unsigned_i = 1'b0;
        addr_i = '0;
        store_data_i = '0;
        alu_result_i = '0;
        csr_op_i = CSR_NONE;
        csr_index_i = 12'h000;
        csr_wdata_i = '0;
        inst_ecall_i = 1'b0;
        inst_mret_i = 1'b0;
        inst_pc_i = '0;
        passed = 0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        foreach (rows[i]) begin
            errors_before = errors;
            run_row(rows[i]);
            if (errors == errors_before) begin
                passed++;
                $display("ok     %s", rows[i].name);
            end else begin
                $display("failed %s", rows[i].name);
            end
        end
        @(negedge clk);
        inst_valid_i = 1'b0;
        repeat (2) @(posedge clk);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 rows.size(), passed, rows.size() - passed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_wb_mem.sv ====
module tb_wb_mem #(
    parameter int unsigned SEED = 32'heaa0_6611
) (
    input  logic        clk_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [63:0] adr_i,
    input  logic [63:0] dat_i,
    input  logic [7:0]  sel_i,
    output logic [63:0] dat_o,
    output logic        ack_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] mem [0:4095];    // 4 KiB, address wraps.

    initial begin
        int unsigned wait_n;
        logic        pending;
        logic [11:0] base;
        void'($urandom(SEED));
        for (int a = 0; a < 4096; a++) begin
            mem[a] = 8'(a ^ (a >> 4));
        end
        ack_o = 1'b0;
        dat_o = '0;
        pending = 1'b0;
        wait_n = 0;
        forever begin
            @(posedge clk_i);
            if (ack_o || !(cyc_i && stb_i)) begin
                ack_o <= 1'b0;    // Master drops the cycle after ack.
                pending = 1'b0;
            end else begin
                if (!pending) begin
                    pending = 1'b1;
                    wait_n = $urandom % 4;    // Wait states for this cycle.
                end
                if (wait_n == 0) begin
                    base = {adr_i[11:3], 3'b000};
                    for (int i = 0; i < 8; i++) begin
                        dat_o[8*i +: 8] <= mem[base + i];
                    end
                    if (we_i) begin
                        for (int i = 0; i < 8; i++) begin
                            if (sel_i[i]) begin
                                mem[base + i] = dat_i[8*i +: 8];
                            end
                        end
                    end
                    ack_o <= 1'b1;
                    pending = 1'b0;
                end else begin
                    wait_n--;
                end
            end
        end
    end

endmodule

// ==== rtl/mem_top.sv ====
module mem_top #(
    parameter logic [mem_pkg::XLEN-1:0] CLINT_BASE  = 64'h0200_0000,
    parameter logic [mem_pkg::XLEN-1:0] MTVEC_RESET = 64'h8000_0100
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     inst_valid_i,
    input  logic                     mem_read_i,
    input  logic                     mem_write_i,
    input  mem_pkg::ls_size_e        ls_size_i,
    input  logic                     load_unsigned_i,
    input  logic [mem_pkg::XLEN-1:0] addr_i,
    input  logic [mem_pkg::XLEN-1:0] store_data_i,
    input  logic [mem_pkg::XLEN-1:0] alu_result_i,
    input  mem_pkg::csr_op_e         csr_op_i,
    input  logic [11:0]              csr_index_i,
    input  logic [mem_pkg::XLEN-1:0] csr_wdata_i,
    input  logic                     inst_ecall_i,
    input  logic                     inst_mret_i,
    input  logic [mem_pkg::XLEN-1:0] inst_pc_i,
    output logic                     access_ok_o,
    output logic [mem_pkg::XLEN-1:0] rd_data_o,
    output logic                     redirect_o,
    output logic [mem_pkg::XLEN-1:0] nxt_pc_o,
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic                     wb_we_o,
    output logic [mem_pkg::XLEN-1:0] wb_adr_o,
    output logic [mem_pkg::XLEN-1:0] wb_dat_o,
    output logic [7:0]               wb_sel_o,
    input  logic [mem_pkg::XLEN-1:0] wb_dat_i,
    input  logic                     wb_ack_i
);
    import mem_pkg::*;

    logic [XLEN-1:0] csr_old;
    logic [XLEN-1:0] raw_rdata;
    logic [XLEN-1:0] lsu_wdata;
    logic [XLEN-1:0] lsu_rdata;
    logic [7:0]      lsu_sel;
    logic            commit;
    logic            mtip;

    mem_bus_if cpu_bus ();
    mem_bus_if clint_bus ();
    mem_bus_if ext_bus ();

    mem_ctrl u_ctrl (
        .clk             (clk),
        .reset_i         (reset_i),
        .inst_valid_i    (inst_valid_i),
        .mem_read_i      (mem_read_i),
        .mem_write_i     (mem_write_i),
        .ls_size_i       (ls_size_i),
        .load_unsigned_i (load_unsigned_i),
        .addr_i          (addr_i),
        .store_data_i    (store_data_i),
        .alu_result_i    (alu_result_i),
        .csr_op_i        (csr_op_i),
        .csr_old_i       (csr_old),
        .sel_i           (lsu_sel),
        .wdata_i         (lsu_wdata),
        .rdata_i         (lsu_rdata),
        .bus             (cpu_bus.master),
        .raw_rdata_o     (raw_rdata),
        .commit_o        (commit),
        .access_ok_o     (access_ok_o),
        .rd_data_o       (rd_data_o)
    );

    mem_lsu_align u_lsu_align (
        .addr_i          (addr_i[2:0]),
        .ls_size_i       (ls_size_i),
        .load_unsigned_i (load_unsigned_i),
        .store_data_i    (store_data_i),
        .raw_rdata_i     (raw_rdata),
        .sel_o           (lsu_sel),
        .wdata_o         (lsu_wdata),
        .rdata_o         (lsu_rdata)
    );

    mem_dstb #(
        .CLINT_BASE (CLINT_BASE)
    ) u_dstb (
        .cpu   (cpu_bus.slave),
        .clint (clint_bus.master),
        .ext   (ext_bus.master)
    );

    mem_clint #(
        .CLINT_BASE (CLINT_BASE)
    ) u_clint (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (clint_bus.slave),
        .mtip_o  (mtip)
    );

    mem_csr #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr (
        .clk          (clk),
        .reset_i      (reset_i),
        .commit_i     (commit),
        .csr_op_i     (csr_op_i),
        .csr_index_i  (csr_index_i),
        .csr_wdata_i  (csr_wdata_i),
        .inst_ecall_i (inst_ecall_i),
        .inst_mret_i  (inst_mret_i),
        .inst_pc_i    (inst_pc_i),
        .mtip_i       (mtip),
        .csr_old_o    (csr_old),
        .redirect_o   (redirect_o),
        .nxt_pc_o     (nxt_pc_o)
    );

    // External Wishbone port.
    assign wb_cyc_o = ext_bus.cyc;
    assign wb_stb_o = ext_bus.stb;
    assign wb_we_o = ext_bus.we;
    assign wb_adr_o = ext_bus.adr;
    assign wb_dat_o = ext_bus.dat_w;
    assign wb_sel_o = ext_bus.sel;
    assign ext_bus.dat_r = wb_dat_i;
    assign ext_bus.ack = wb_ack_i;

endmodule

// ==== rtl/mem_csr.sv ====
module mem_csr #(
    parameter logic [mem_pkg::XLEN-1:0] MTVEC_RESET = 64'h8000_0100
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     commit_i,
    input  mem_pkg::csr_op_e         csr_op_i,
    input  logic [11:0]              csr_index_i,
    input  logic [mem_pkg::XLEN-1:0] csr_wdata_i,
    input  logic                     inst_ecall_i,
    input  logic                     inst_mret_i,
    input  logic [mem_pkg::XLEN-1:0] inst_pc_i,
    input  logic                     mtip_i,
    output logic [mem_pkg::XLEN-1:0] csr_old_o,
    output logic                     redirect_o,
    output logic [mem_pkg::XLEN-1:0] nxt_pc_o
);
    import mem_pkg::*;

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] csr_new;
    logic            intr;
    logic            trap;

    always_comb begin
        mip = '0;
        mip[MIE_MTIE_BIT] = mtip_i;    // MTIP mirror, read only.
    end

    assign intr = mip[MIE_MTIE_BIT] & mie_q[MIE_MTIE_BIT] & mstatus_q[MSTATUS_MIE_BIT];
    assign trap = intr | inst_ecall_i;

    always_comb begin
        case (csr_index_i)
            CSR_MSTATUS:  csr_old_o = mstatus_q;
            CSR_MIE:      csr_old_o = mie_q;
            CSR_MTVEC:    csr_old_o = mtvec_q;
            CSR_MSCRATCH: csr_old_o = mscratch_q;
            CSR_MEPC:     csr_old_o = mepc_q;
            CSR_MCAUSE:   csr_old_o = mcause_q;
            CSR_MIP:      csr_old_o = mip;
            default:      csr_old_o = '0;
        endcase
    end

    always_comb begin
        case (csr_op_i)
            CSR_WRITE: csr_new = csr_wdata_i;
            CSR_SET:   csr_new = csr_old_o | csr_wdata_i;
            CSR_CLEAR: csr_new = csr_old_o & ~csr_wdata_i;
            default:   csr_new = csr_old_o;
        endcase
    end

    assign redirect_o = commit_i & (trap | inst_mret_i);
    assign nxt_pc_o = trap ? {mtvec_q[XLEN-1:2], 2'b00} : mepc_q;    // Direct mode only.

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mstatus_q <= '0;
            mtvec_q <= MTVEC_RESET;
            mepc_q <= '0;
            mcause_q <= '0;
            mie_q <= '0;
            mscratch_q <= '0;
        end else if (commit_i) begin
            if (trap) begin
                mepc_q <= inst_pc_i;    // Interrupted instruction is replayed.
                mcause_q <= intr ? CAUSE_TIMER_INT : CAUSE_ECALL_M;
                mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
                mstatus_q[MSTATUS_MIE_BIT] <= 1'b0;
            end else if (inst_mret_i) begin
                mstatus_q[MSTATUS_MIE_BIT] <= mstatus_q[MSTATUS_MPIE_BIT];
                mstatus_q[MSTATUS_MPIE_BIT] <= 1'b1;
            end else if (csr_op_i != CSR_NONE) begin
                case (csr_index_i)
                    CSR_MSTATUS:  mstatus_q <= csr_new;
                    CSR_MIE:      mie_q <= csr_new;
                    CSR_MTVEC:    mtvec_q <= csr_new;
                    CSR_MSCRATCH: mscratch_q <= csr_new;
                    CSR_MEPC:     mepc_q <= csr_new;
                    CSR_MCAUSE:   mcause_q <= csr_new;
                    default:      ;
                endcase
            end
        end
    end

endmodule

// ==== rtl/mem_clint.sv ====
module mem_clint #(
    parameter logic [mem_pkg::XLEN-1:0] CLINT_BASE = 64'h0200_0000
) (
    input  logic      clk,
    input  logic      reset_i,
    mem_bus_if.slave  bus,
    output logic      mtip_o
);
    import mem_pkg::*;

    logic [XLEN-1:0] mtime_q;
    logic [XLEN-1:0] mtimecmp_q;
    logic [XLEN-1:0] rdata_q;
    logic [XLEN-1:0] ofs;
    logic            ack_q;
    logic            access;
    logic            hit_cmp;
    logic            hit_time;

    function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old_v,
                                                    input logic [XLEN-1:0] new_v,
                                                    input logic [7:0]      sel);
        logic [XLEN-1:0] res;
        res = old_v;
        for (int i = 0; i < 8; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign ofs = bus.adr - CLINT_BASE;
    assign hit_cmp = (ofs[XLEN-1:3] == CLINT_MTIMECMP_OFS[XLEN-1:3]);
    assign hit_time = (ofs[XLEN-1:3] == CLINT_MTIME_OFS[XLEN-1:3]);
    assign access = bus.cyc & bus.stb & ~ack_q;    // First cycle of a request.

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
            mtime_q <= '0;
            mtimecmp_q <= '0;
            mtip_o <= 1'b0;
        end else begin
            ack_q <= access;
            mtip_o <= (mtime_q >= mtimecmp_q);
            if (access && bus.we && hit_time) begin
                mtime_q <= merge_bytes(mtime_q, bus.dat_w, bus.sel);
            end else begin
                mtime_q <= mtime_q + XLEN'(1);
            end
            if (access && bus.we && hit_cmp) begin
                mtimecmp_q <= merge_bytes(mtimecmp_q, bus.dat_w, bus.sel);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= hit_cmp ? mtimecmp_q : (hit_time ? mtime_q : '0);
        end
    end

    assign bus.dat_r = rdata_q;
    assign bus.ack = ack_q;

endmodule

// ==== rtl/mem_dstb.sv ====
module mem_dstb #(
    parameter logic [mem_pkg::XLEN-1:0] CLINT_BASE = 64'h0200_0000
) (
    mem_bus_if.slave  cpu,
    mem_bus_if.master clint,
    mem_bus_if.master ext
);
    import mem_pkg::*;

    logic hit;

    assign hit = (cpu.adr[XLEN-1:16] == CLINT_BASE[XLEN-1:16]);    // 64 KiB window.

    assign clint.cyc = cpu.cyc & hit;
    assign clint.stb = cpu.stb & hit;
    assign clint.we = cpu.we;
    assign clint.adr = cpu.adr;
    assign clint.dat_w = cpu.dat_w;
    assign clint.sel = cpu.sel;

    assign ext.cyc = cpu.cyc & ~hit;
    assign ext.stb = cpu.stb & ~hit;
    assign ext.we = cpu.we;
    assign ext.adr = cpu.adr;
    assign ext.dat_w = cpu.dat_w;
    assign ext.sel = cpu.sel;

    assign cpu.dat_r = hit ? clint.dat_r : ext.dat_r;
    assign cpu.ack = hit ? clint.ack : ext.ack;

    always_comb begin
        a_one_side: assert #0 (!(clint.ack && ext.ack));
    end

endmodule

// ==== rtl/mem_lsu_align.sv ====
module mem_lsu_align (
    input  logic [2:0]               addr_i,
    input  mem_pkg::ls_size_e        ls_size_i,
    input  logic                     load_unsigned_i,
    input  logic [mem_pkg::XLEN-1:0] store_data_i,
    input  logic [mem_pkg::XLEN-1:0] raw_rdata_i,
    output logic [7:0]               sel_o,
    output logic [mem_pkg::XLEN-1:0] wdata_o,
    output logic [mem_pkg::XLEN-1:0] rdata_o
);
    import mem_pkg::*;

    logic [5:0]      shamt;
    logic [XLEN-1:0] shifted;
    logic            sign_b;
    logic            sign_h;
    logic            sign_w;

    assign shamt = {addr_i, 3'b000};
    assign shifted = raw_rdata_i >> shamt;    // Addressed lanes down to lane 0.

    assign sign_b = ~load_unsigned_i & shifted[7];
    assign sign_h = ~load_unsigned_i & shifted[15];
    assign sign_w = ~load_unsigned_i & shifted[31];

    always_comb begin
        case (ls_size_i)
            LS_BYTE: begin
                sel_o = 8'h01 << addr_i;
                wdata_o = {8{store_data_i[7:0]}};
                rdata_o = {{(XLEN - 8){sign_b}}, shifted[7:0]};
            end
            LS_HALF: begin
                sel_o = 8'h03 << addr_i;
                wdata_o = {4{store_data_i[15:0]}};
                rdata_o = {{(XLEN - 16){sign_h}}, shifted[15:0]};
            end
            LS_WORD: begin
                sel_o = 8'h0f << addr_i;
                wdata_o = {2{store_data_i[31:0]}};
                rdata_o = {{(XLEN - 32){sign_w}}, shifted[31:0]};
            end
            default: begin
                sel_o = 8'hff;
                wdata_o = store_data_i;
                rdata_o = shifted;
            end
        endcase
    end

endmodule

// ==== rtl/mem_ctrl.sv ====
module mem_ctrl (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     inst_valid_i,
    input  logic                     mem_read_i,
    input  logic                     mem_write_i,
    input  mem_pkg::ls_size_e        ls_size_i,
    input  logic                     load_unsigned_i,
    input  logic [mem_pkg::XLEN-1:0] addr_i,
    input  logic [mem_pkg::XLEN-1:0] store_data_i,
    input  logic [mem_pkg::XLEN-1:0] alu_result_i,
    input  mem_pkg::csr_op_e         csr_op_i,
    input  logic [mem_pkg::XLEN-1:0] csr_old_i,
    input  logic [7:0]               sel_i,
    input  logic [mem_pkg::XLEN-1:0] wdata_i,
    input  logic [mem_pkg::XLEN-1:0] rdata_i,
    mem_bus_if.master                bus,
    output logic [mem_pkg::XLEN-1:0] raw_rdata_o,
    output logic                     commit_o,
    output logic                     access_ok_o,
    output logic [mem_pkg::XLEN-1:0] rd_data_o
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_DONE
    } state_e;

    state_e          state_q;
    logic [XLEN-1:0] load_q;
    logic            mem_req;

    assign mem_req = mem_read_i | mem_write_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (inst_valid_i) begin
                        state_q <= mem_req ? S_BUS : S_DONE;
                    end
                end
                S_BUS: begin
                    if (bus.ack) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;    // One-cycle completion pulse.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_BUS && bus.ack) begin
            load_q <= rdata_i;    // Already aligned and extended.
        end
    end

    assign bus.cyc = (state_q == S_BUS);
    assign bus.stb = (state_q == S_BUS);
    assign bus.we = mem_write_i;
    assign bus.adr = addr_i;
    assign bus.dat_w = wdata_i;
    assign bus.sel = sel_i;
    assign raw_rdata_o = bus.dat_r;

    assign commit_o = (state_q == S_DONE);
    assign access_ok_o = (state_q == S_DONE);

    always_comb begin
        if (mem_read_i) begin
            rd_data_o = load_q;
        end else if (csr_op_i != CSR_NONE) begin
            rd_data_o = csr_old_i;
        end else begin
            rd_data_o = alu_result_i;
        end
    end

    a_stb_hold: assert property (@(posedge clk) disable iff (reset_i)
        bus.stb && !bus.ack |=> bus.stb && $stable({bus.we, bus.adr, bus.dat_w, bus.sel}));

    a_ld_st_excl: assert property (@(posedge clk) disable iff (reset_i)
        inst_valid_i |-> !(mem_read_i && mem_write_i));

    a_aligned: assert property (@(posedge clk) disable iff (reset_i)
        inst_valid_i && mem_req |-> (addr_i[2:0] & 3'((4'd1 << ls_size_i) - 4'd1)) == 3'd0);

    // Pipeline must hold the instruction until completion.
    a_inst_stable: assert property (@(posedge clk) disable iff (reset_i)
        inst_valid_i && !access_ok_o |=>
            $stable({inst_valid_i, mem_read_i, mem_write_i, ls_size_i, load_unsigned_i,
                     addr_i, store_data_i}));

endmodule

// ==== rtl/mem_bus_if.sv ====
interface mem_bus_if;
    import mem_pkg::*;

    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:0] adr;    // Byte address.
    logic [XLEN-1:0] dat_w;
    logic [7:0]      sel;
    logic [XLEN-1:0] dat_r;
    logic            ack;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );

endinterface

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    localparam int XLEN = 64;

    typedef enum logic [1:0] {
        LS_BYTE   = 2'd0,
        LS_HALF   = 2'd1,
        LS_WORD   = 2'd2,
        LS_DOUBLE = 2'd3
    } ls_size_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MIE      = 12'h304;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MIP      = 12'h344;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MTIE_BIT     = 7;    // Same position as mip.MTIP.

    localparam logic [XLEN-1:0] CAUSE_ECALL_M   = XLEN'(11);
    localparam logic [XLEN-1:0] CAUSE_TIMER_INT = (XLEN'(1) << (XLEN - 1)) | XLEN'(7);

    // Offsets inside the 64 KiB CLINT window.
    localparam logic [XLEN-1:0] CLINT_MTIMECMP_OFS = XLEN'(16'h4000);
    localparam logic [XLEN-1:0] CLINT_MTIME_OFS    = XLEN'(16'hBFF8);

endpackage
